/* common/spi_regs_cfg.svh */
`ifndef SPI_REGS_CFG_SVH
`define SPI_REGS_CFG_SVH

// --------------------------------------------------
// SPI mode
// --------------------------------------------------

// Idle level of SCK
`define SPI_CPOL 1'b0

// Data changes on the leading edge when set
`define SPI_CPHA 1'b1

// --------------------------------------------------
// Register bank
// --------------------------------------------------

`define SPI_REG_COUNT 16
`define SPI_ADDR_W 4

`endif

/* common/spi_regs_pkg.sv */
`include "spi_regs_cfg.svh"

package spi_regs_pkg;

    // --------------------------------------------------
    // Frame words
    // --------------------------------------------------

    // Command byte, first of every frame
    typedef struct packed {
        logic                   rd;
        logic [2:0]             rsvd;
        logic [`SPI_ADDR_W-1:0] addr;
    } spi_cmd_t;

    // Same received byte, command or data depending on position
    typedef union packed {
        spi_cmd_t   cmd;
        logic [7:0] data;
    } spi_word_u;

    // One received byte and its position in the frame
    typedef struct packed {
        spi_word_u word;
        logic      first;
    } spi_rx_beat_t;

    // --------------------------------------------------
    // Register bank
    // --------------------------------------------------

    // Element 0 sits in the low byte
    typedef logic [`SPI_REG_COUNT-1:0][7:0] spi_regs_t;

endpackage

/* spi_core/spi_sync_edge.sv */
`timescale 1ns/100ps

`include "spi_regs_cfg.svh"

module spi_sync_edge (
    input  logic aclk,
    input  logic aresetn,
    input  logic sck,
    input  logic ss_n,
    input  logic mosi,
    output logic capture_stb,
    output logic output_stb,
    output logic frame_active,
    output logic mosi_s
);

    // Modes 1 and 2 sample on the falling edge
    localparam logic CAPTURE_ON_FALL = `SPI_CPOL ^ `SPI_CPHA;

    logic [1:0] sck_sync;
    logic [1:0] ss_sync;
    logic [1:0] mosi_sync;
    logic       sck_d;
    logic       sck_rise;
    logic       sck_fall;

    // --------------------------------------------------
    // Two-flop synchronizers
    // --------------------------------------------------

    // SCK starts at its idle level, SS deselected
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sck_sync <= {2{`SPI_CPOL}};
            ss_sync  <= 2'b11;
            sck_d    <= `SPI_CPOL;
        end else begin
            sck_sync <= {sck_sync[0], sck};
            ss_sync  <= {ss_sync[0], ss_n};
            sck_d    <= sck_sync[1];
        end
    end

    always_ff @(posedge aclk) begin
        mosi_sync <= {mosi_sync[0], mosi};
    end

    assign mosi_s       = mosi_sync[1];
    assign frame_active = !ss_sync[1];

    // --------------------------------------------------
    // Edge strobes
    // --------------------------------------------------

    assign sck_rise = sck_sync[1] && !sck_d && frame_active;
    assign sck_fall = !sck_sync[1] && sck_d && frame_active;

    assign capture_stb = CAPTURE_ON_FALL ? sck_fall : sck_rise;
    assign output_stb  = CAPTURE_ON_FALL ? sck_rise : sck_fall;

endmodule

/* spi_core/spi_rx_deser.sv */
`timescale 1ns/100ps

module spi_rx_deser (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       capture_stb,
    input  logic                       frame_active,
    input  logic                       mosi_s,
    output spi_regs_pkg::spi_rx_beat_t rx_beat,
    output logic                       rx_stb
);

    logic [6:0] rx_shift;
    logic [2:0] bit_cnt;
    logic       first_byte;

    // --------------------------------------------------
    // Bit counter
    // --------------------------------------------------

    // Held at zero between frames so a cut byte is dropped
    always_ff @(posedge aclk) begin
        if (!aresetn || !frame_active) begin
            bit_cnt <= 3'd0;
        end else if (capture_stb) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // MSB first, newest bit at the bottom
    always_ff @(posedge aclk) begin
        if (capture_stb) begin
            rx_shift <= {rx_shift[5:0], mosi_s};
        end
    end

    // --------------------------------------------------
    // Frame position
    // --------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn || !frame_active) begin
            first_byte <= 1'b1;
        end else if (rx_stb) begin
            first_byte <= 1'b0;
        end
    end

    // Last bit comes straight from the pin side
    assign rx_stb  = capture_stb && (bit_cnt == 3'd7);
    assign rx_beat = {rx_shift, mosi_s, first_byte};

endmodule

/* spi_core/spi_tx_ser.sv */
`timescale 1ns/100ps

`include "spi_regs_cfg.svh"

module spi_tx_ser (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       output_stb,
    input  logic       frame_active,
    input  logic       ss_n,
    input  logic [7:0] tx_word,
    output logic       miso,
    output logic       miso_oe
);

    // Phase 1 loads on the first output edge of a slot,
    // phase 0 on the last one, ahead of the next slot
    localparam logic [2:0] LOAD_CNT = `SPI_CPHA ? 3'd0 : 3'd7;

    logic [2:0] bit_cnt;
    logic       past_first;
    logic [7:0] tx_shift;
    logic       load;

    // --------------------------------------------------
    // Slot tracking
    // --------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn || !frame_active) begin
            bit_cnt <= 3'd0;
        end else if (output_stb) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // Set once the command slot has been shifted out
    always_ff @(posedge aclk) begin
        if (!aresetn || !frame_active) begin
            past_first <= 1'b0;
        end else if (output_stb && (bit_cnt == 3'd7)) begin
            past_first <= 1'b1;
        end
    end

    // Command slot keeps the cleared register, so it sends 0x00
    assign load = output_stb && (bit_cnt == LOAD_CNT) && (!`SPI_CPHA || past_first);

    // --------------------------------------------------
    // Shift register
    // --------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn || !frame_active) begin
            tx_shift <= 8'h00;
        end else if (load) begin
            tx_shift <= tx_word;
        end else if (output_stb) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign miso = tx_shift[7];

    // Driven straight from the pin, no sync delay
    assign miso_oe = !ss_n;

endmodule

/* verilog/spi_reg_ctrl.sv */
`timescale 1ns/100ps

`include "spi_regs_cfg.svh"

module spi_reg_ctrl (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       rx_stb,
    input  spi_regs_pkg::spi_rx_beat_t rx_beat,
    output logic [7:0]                 tx_word,
    output spi_regs_pkg::spi_regs_t    regs
);

    import spi_regs_pkg::*;

    spi_cmd_t               cmd;
    logic                   rd_mode;
    logic [`SPI_ADDR_W-1:0] addr;
    logic [`SPI_ADDR_W-1:0] addr_next;
    logic                   cmd_stb;
    logic                   data_stb;

    // --------------------------------------------------
    // Beat decode
    // --------------------------------------------------

    assign cmd = rx_beat.word.cmd;

    assign cmd_stb  = rx_stb && rx_beat.first;
    assign data_stb = rx_stb && !rx_beat.first;

    // Wraps at the top of the bank
    assign addr_next = addr + 1'b1;

    // --------------------------------------------------
    // Frame state
    // --------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_mode <= 1'b0;
            addr    <= '0;
        end else if (cmd_stb) begin
            rd_mode <= cmd.rd;
            addr    <= cmd.addr;
        end else if (data_stb) begin
            addr <= addr_next;
        end
    end

    // --------------------------------------------------
    // Read data
    // --------------------------------------------------

    // Next slot's byte, ready one cycle after the strobe
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tx_word <= 8'h00;
        end else if (cmd_stb) begin
            tx_word <= cmd.rd ? regs[cmd.addr] : 8'h00;
        end else if (data_stb && rd_mode) begin
            tx_word <= regs[addr_next];
        end
    end

    // --------------------------------------------------
    // Register bank
    // --------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            regs <= '0;
        end else if (data_stb && !rd_mode) begin
            regs[addr] <= rx_beat.word.data;
        end
    end

endmodule

/* verilog/spi_regs_top.sv */
`timescale 1ns/100ps

module spi_regs_top (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    sck,
    input  logic                    ss_n,
    input  logic                    mosi,
    output logic                    miso,
    output logic                    miso_oe,
    output spi_regs_pkg::spi_regs_t regs
);

    import spi_regs_pkg::*;

    logic         capture_stb;
    logic         output_stb;
    logic         frame_active;
    logic         mosi_s;
    spi_rx_beat_t rx_beat;
    logic         rx_stb;
    logic [7:0]   tx_word;

    // --------------------------------------------------
    // Pin side
    // --------------------------------------------------

    spi_sync_edge u_sync_edge (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .sck          (sck),
        .ss_n         (ss_n),
        .mosi         (mosi),
        .capture_stb  (capture_stb),
        .output_stb   (output_stb),
        .frame_active (frame_active),
        .mosi_s       (mosi_s)
    );

    spi_rx_deser u_rx_deser (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .capture_stb  (capture_stb),
        .frame_active (frame_active),
        .mosi_s       (mosi_s),
        .rx_beat      (rx_beat),
        .rx_stb       (rx_stb)
    );

    // --------------------------------------------------
    // Protocol and output
    // --------------------------------------------------

    spi_reg_ctrl u_reg_ctrl (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rx_stb  (rx_stb),
        .rx_beat (rx_beat),
        .tx_word (tx_word),
        .regs    (regs)
    );

    spi_tx_ser u_tx_ser (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .output_stb   (output_stb),
        .frame_active (frame_active),
        .ss_n         (ss_n),
        .tx_word      (tx_word),
        .miso         (miso),
        .miso_oe      (miso_oe)
    );

endmodule

/* verif/spi_regs_tb.sv */
`timescale 1ns/100ps

`include "spi_regs_cfg.svh"

module spi_regs_tb;

    import spi_regs_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int HALF        = 10;
    localparam int GAP         = 12;
    localparam int NUM_FRAMES  = 40;
    // Worst case frame is 21 bytes of 8 bits with two half periods per bit
    localparam int WATCHDOG_NS = NUM_FRAMES * 21 * 8 * (2 * HALF) * CLK_NS + 200000;

    logic      aclk;
    logic      aresetn;
    logic      sck;
    logic      ss_n;
    logic      mosi;
    logic      miso;
    logic      miso_oe;
    spi_regs_t regs;

    spi_regs_t model;
    integer    seed;
    int        reg_errors;
    int        byte_errors;
    int        bit_errors;

    spi_regs_top dut0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .sck     (sck),
        .ss_n    (ss_n),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe),
        .regs    (regs)
    );

    always #(CLK_NS / 2) aclk = ~aclk;

    // --------------------------------------------------
    // Helpers and compare tasks
    // --------------------------------------------------

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    task automatic check_regs(input spi_regs_t got, input spi_regs_t exp);
        int i;
        for (i = 0; i < `SPI_REG_COUNT; i++) begin
            if (got[i] !== exp[i]) begin
                reg_errors++;
                $display("MISMATCH at %0t: register %0d holds %02h, expected %02h",
                         $time, i, got[i], exp[i]);
            end
        end
    endtask

    // Negative address marks a slot that reads no register
    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int addr);
        if (got !== exp) begin
            byte_errors++;
            if (addr < 0) begin
                $display("MISMATCH at %0t: MISO outside a read slot gave %02h, expected %02h",
                         $time, got, exp);
            end else begin
                $display("MISMATCH at %0t: read of register %0d gave %02h, expected %02h",
                         $time, addr, got, exp);
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Output enable tracks the select pin at all times
    always @(negedge aclk) begin
        check_bit("miso_oe", miso_oe, !ss_n);
    end

    // --------------------------------------------------
    // SPI master
    // --------------------------------------------------

    task automatic spi_xfer_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        int i;
        rx = 8'h00;
        for (i = 7; i > 7 - nbits; i--) begin
            if (`SPI_CPHA == 1'b0) begin
                mosi = tx[i];
                wait_cycles(HALF);
                sck = !`SPI_CPOL;
                rx[i] = miso;
                wait_cycles(HALF);
                sck = `SPI_CPOL;
            end else begin
                sck = !`SPI_CPOL;
                mosi = tx[i];
                wait_cycles(HALF);
                sck = `SPI_CPOL;
                rx[i] = miso;
                wait_cycles(HALF);
            end
        end
    endtask

    task automatic start_frame();
        ss_n = 1'b0;
        wait_cycles(HALF);
    endtask

    task automatic end_frame();
        wait_cycles(HALF);
        ss_n = 1'b1;
        mosi = 1'b0;
        wait_cycles(GAP);
    endtask

    // Nonzero cut_bits leaves a partial byte before SS rises
    task automatic spi_frame_write(input int addr, input int len, input int cut_bits);
        spi_cmd_t   cmd;
        logic [7:0] data;
        logic [7:0] rx;
        int         i;
        cmd.rd   = 1'b0;
        cmd.rsvd = 3'(rand_below(8));
        cmd.addr = 4'(addr);
        start_frame();
        spi_xfer_byte(cmd, 8, rx);
        check_byte(rx, 8'h00, -1);
        for (i = 0; i < len; i++) begin
            data = 8'(rand_below(256));
            spi_xfer_byte(data, 8, rx);
            check_byte(rx, 8'h00, -1);
            model[4'(addr + i)] = data;
        end
        if (cut_bits > 0) begin
            data = 8'(rand_below(256));
            spi_xfer_byte(data, cut_bits, rx);
            check_byte(rx, 8'h00, -1);
        end
        end_frame();
        check_regs(regs, model);
    endtask

    task automatic spi_frame_read(input int addr, input int len);
        spi_cmd_t   cmd;
        logic [7:0] rx;
        int         i;
        cmd.rd   = 1'b1;
        cmd.rsvd = 3'(rand_below(8));
        cmd.addr = 4'(addr);
        start_frame();
        spi_xfer_byte(cmd, 8, rx);
        check_byte(rx, 8'h00, -1);
        for (i = 0; i < len; i++) begin
            // MOSI content is junk in a read frame
            spi_xfer_byte(8'(rand_below(256)), 8, rx);
            check_byte(rx, model[4'(addr + i)], (addr + i) % `SPI_REG_COUNT);
        end
        end_frame();
        check_regs(regs, model);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        int frame;
        int kind;
        int addr;
        aclk        = 1'b0;
        aresetn     = 1'b0;
        sck         = `SPI_CPOL;
        ss_n        = 1'b1;
        mosi        = 1'b0;
        seed        = 32'h5315f106;
        model       = '0;
        reg_errors  = 0;
        byte_errors = 0;
        bit_errors  = 0;
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        wait_cycles(4);
        check_regs(regs, model);
        check_bit("miso", miso, 1'b0);
        for (frame = 0; frame < NUM_FRAMES; frame++) begin
            kind = rand_below(8);
            addr = rand_below(`SPI_REG_COUNT);
            if (kind < 3) begin
                spi_frame_write(addr, 1 + rand_below(20), 0);
            end else if (kind < 6) begin
                spi_frame_read(addr, 1 + rand_below(20));
            end else begin
                spi_frame_write(addr, rand_below(4), 1 + rand_below(7));
            end
        end
        $display("Errors: registers %0d, read bytes %0d, pin checks %0d",
                 reg_errors, byte_errors, bit_errors);
        if (reg_errors + byte_errors + bit_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the frame sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* spi_regs.f */
+incdir+common
common/spi_regs_pkg.sv
spi_core/spi_sync_edge.sv
spi_core/spi_rx_deser.sv
spi_core/spi_tx_ser.sv
verilog/spi_reg_ctrl.sv
verilog/spi_regs_top.sv
verif/spi_regs_tb.sv

/* Makefile */
SIM        := verilator
TOP        := spi_regs_tb
RTL_TOP    := spi_regs_top
FILELIST   := spi_regs.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Passes only when the simulation prints the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
